//--- hdl/exu_isa_pkg.sv
////////////////////////////////////////
// ISA widths and encodings for the reduced RV32 execution stage
// Shared by decode and the datapath modules
////////////////////////////////////////

package exu_isa_pkg;

  localparam int unsigned XLEN    = 32;
  localparam int unsigned RFIDX_W = 5;
  localparam int unsigned INSTR_W = 32;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NONE  // Loads and illegal encodings
  } alu_op_e;

  // funct3
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_LW  = 3'b010;

  // funct7
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

//--- hdl/exu_pipe_pkg.sv
////////////////////////////////////////
// Packed structs passed between the execution stage modules
////////////////////////////////////////

package exu_pipe_pkg;

  // Tag field width on the LSU ports, enough for 16 OITF entries
  localparam int unsigned ITAG_FW = 4;

  typedef struct packed {
    logic                                valid;   // Legal instruction
    logic                                is_load;
    exu_isa_pkg::alu_op_e                alu_op;
    logic                                rs1en;
    logic                                rs2en;
    logic                                rdwen;   // Never set for x0
    logic [exu_isa_pkg::RFIDX_W-1:0]     rs1idx;
    logic [exu_isa_pkg::RFIDX_W-1:0]     rs2idx;
    logic [exu_isa_pkg::RFIDX_W-1:0]     rdidx;
    logic [exu_isa_pkg::XLEN-1:0]        imm;
  } dec_info_t;

  typedef struct packed {
    exu_isa_pkg::alu_op_e                alu_op;
    logic [exu_isa_pkg::XLEN-1:0]        op1;
    logic [exu_isa_pkg::XLEN-1:0]        op2;
    logic                                rdwen;
    logic [exu_isa_pkg::RFIDX_W-1:0]     rdidx;
  } alu_req_t;

  typedef struct packed {
    logic                                ena;
    logic [exu_isa_pkg::RFIDX_W-1:0]     rdidx;
    logic [exu_isa_pkg::XLEN-1:0]        wdat;
  } wbck_t;

  typedef struct packed {
    logic [exu_isa_pkg::XLEN-1:0]        addr;
    logic [ITAG_FW-1:0]                  itag;
  } ld_req_t;

  typedef struct packed {
    logic [exu_isa_pkg::XLEN-1:0]        wdat;
    logic [ITAG_FW-1:0]                  itag;
  } lsu_rsp_t;

  typedef struct packed {
    logic rs1_pend;  // Hit on a younger entry
    logic rs2_pend;
    logic rd_pend;   // Any entry
    logic rs1_ret;   // Hit on the head entry
    logic rs2_ret;
  } oitf_match_t;

  typedef struct packed {
    logic                                ena;
    logic                                rdwen;
    logic [exu_isa_pkg::RFIDX_W-1:0]     rdidx;
  } ret_t;

endpackage

//--- hdl/exu_decode.sv
////////////////////////////////////////
// Instruction decoder for ADD SUB AND OR XOR ADDI and LW
// Purely combinational, feeds dispatch and the register file
////////////////////////////////////////
`timescale 1ns/100ps

module exu_decode (
  input  logic [exu_isa_pkg::INSTR_W-1:0] i_instr,
  output exu_pipe_pkg::dec_info_t         o_dec
);

  exu_isa_pkg::opcode_e opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;

  assign opcode = exu_isa_pkg::opcode_e'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];

  always_comb begin
    o_dec        = '0;
    o_dec.alu_op = exu_isa_pkg::ALU_NONE;
    o_dec.rs1idx = i_instr[19:15];
    o_dec.rs2idx = i_instr[24:20];
    o_dec.rdidx  = i_instr[11:7];
    o_dec.imm    = {{20{i_instr[31]}}, i_instr[31:20]};  // I-type

    case (opcode)
      exu_isa_pkg::OPC_OP: begin
        if (funct7 == exu_isa_pkg::F7_BASE) begin
          case (funct3)
            exu_isa_pkg::F3_ADD: o_dec.alu_op = exu_isa_pkg::ALU_ADD;
            exu_isa_pkg::F3_XOR: o_dec.alu_op = exu_isa_pkg::ALU_XOR;
            exu_isa_pkg::F3_OR:  o_dec.alu_op = exu_isa_pkg::ALU_OR;
            exu_isa_pkg::F3_AND: o_dec.alu_op = exu_isa_pkg::ALU_AND;
            default:             o_dec.alu_op = exu_isa_pkg::ALU_NONE;
          endcase
        end else if (funct7 == exu_isa_pkg::F7_SUB && funct3 == exu_isa_pkg::F3_ADD) begin
          o_dec.alu_op = exu_isa_pkg::ALU_SUB;
        end
        o_dec.valid = (o_dec.alu_op != exu_isa_pkg::ALU_NONE);
        o_dec.rs2en = o_dec.valid;
      end
      exu_isa_pkg::OPC_OP_IMM: begin
        o_dec.valid  = (funct3 == exu_isa_pkg::F3_ADD);  // ADDI only
        o_dec.alu_op = o_dec.valid ? exu_isa_pkg::ALU_ADD : exu_isa_pkg::ALU_NONE;
      end
      exu_isa_pkg::OPC_LOAD: begin
        o_dec.valid   = (funct3 == exu_isa_pkg::F3_LW);
        o_dec.is_load = o_dec.valid;
      end
      default: o_dec.valid = 1'b0;
    endcase

    // All legal ops read rs1 and write rd
    o_dec.rs1en = o_dec.valid;
    o_dec.rdwen = o_dec.valid & (o_dec.rdidx != '0);
  end

endmodule

//--- hdl/exu_regfile.sv
////////////////////////////////////////
// Integer register file, 2 read ports and 1 write port
// x0 is hardwired to zero
////////////////////////////////////////
`timescale 1ns/100ps

module exu_regfile (
  input  logic                            clk,
  input  logic                            i_rst,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_rs2idx,
  output logic [exu_isa_pkg::XLEN-1:0]    o_rs1,
  output logic [exu_isa_pkg::XLEN-1:0]    o_rs2,
  input  exu_pipe_pkg::wbck_t             i_wbck
);

  logic [exu_isa_pkg::XLEN-1:0] rf_q [1:31];  // No storage for x0

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wbck.ena && i_wbck.rdidx != '0) begin
      rf_q[i_wbck.rdidx] <= i_wbck.wdat;
    end
  end

  // Asynchronous read
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf_q[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf_q[i_rs2idx];

endmodule

//--- hdl/exu_oitf.sv
////////////////////////////////////////
// Outstanding instruction FIFO for loads in flight
// Allocated at load issue, retired at LSU response
////////////////////////////////////////
`timescale 1ns/100ps

module exu_oitf #(
  parameter int unsigned OITF_DEPTH = 4,
  parameter int unsigned ITAG_W     = 2
) (
  input  logic                            clk,
  input  logic                            i_rst,
  input  logic                            i_alloc,
  input  logic                            i_alloc_rdwen,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_alloc_rdidx,
  output logic [ITAG_W-1:0]               o_alloc_ptr,
  input  logic                            i_ret_ena,
  output exu_pipe_pkg::ret_t              o_ret,
  input  logic                            i_rs1en,
  input  logic                            i_rs2en,
  input  logic                            i_rdwen,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_rs1idx,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_rs2idx,
  input  logic [exu_isa_pkg::RFIDX_W-1:0] i_rdidx,
  output exu_pipe_pkg::oitf_match_t       o_match,
  output logic                            o_full,
  output logic                            o_empty
);

  logic [ITAG_W-1:0]               wptr_q;
  logic [ITAG_W-1:0]               rptr_q;
  logic                            wwrap_q;
  logic                            rwrap_q;
  logic [OITF_DEPTH-1:0]           vld_q;
  logic [OITF_DEPTH-1:0]           rdwen_q;
  logic [exu_isa_pkg::RFIDX_W-1:0] rdidx_q [OITF_DEPTH];

  ////////////////////////////////////////
  // Pointers and entry valid bits
  always_ff @(posedge clk) begin
    if (i_rst) begin
      {wwrap_q, wptr_q} <= '0;
      {rwrap_q, rptr_q} <= '0;
      vld_q             <= '0;
    end else begin
      if (i_ret_ena) begin
        vld_q[rptr_q]     <= 1'b0;
        {rwrap_q, rptr_q} <= {rwrap_q, rptr_q} + 1'b1;
      end
      if (i_alloc) begin
        vld_q[wptr_q]     <= 1'b1;
        {wwrap_q, wptr_q} <= {wwrap_q, wptr_q} + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_alloc) begin
      rdwen_q[wptr_q] <= i_alloc_rdwen;
      rdidx_q[wptr_q] <= i_alloc_rdidx;
    end
  end

  ////////////////////////////////////////
  // Hazard compare, head entry reported apart
  always_comb begin
    logic hit;
    logic head;
    o_match = '0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      hit  = vld_q[i] & rdwen_q[i];
      head = (ITAG_W'(i) == rptr_q);
      if (hit && i_rs1en && rdidx_q[i] == i_rs1idx) begin
        if (head) o_match.rs1_ret = 1'b1;
        else      o_match.rs1_pend = 1'b1;
      end
      if (hit && i_rs2en && rdidx_q[i] == i_rs2idx) begin
        if (head) o_match.rs2_ret = 1'b1;
        else      o_match.rs2_pend = 1'b1;
      end
      if (hit && i_rdwen && rdidx_q[i] == i_rdidx) o_match.rd_pend = 1'b1;
    end
  end

  assign o_ret.ena   = vld_q[rptr_q];  // Head is outstanding
  assign o_ret.rdwen = rdwen_q[rptr_q];
  assign o_ret.rdidx = rdidx_q[rptr_q];

  assign o_alloc_ptr = wptr_q;
  assign o_full      = (wptr_q == rptr_q) & (wwrap_q != rwrap_q);
  assign o_empty     = (wptr_q == rptr_q) & (wwrap_q == rwrap_q);

endmodule

//--- hdl/exu_disp.sv
////////////////////////////////////////
// Dispatch with operand forwarding and hazard stalls
// Sends ALU ops to the ALU and loads to the LSU port
////////////////////////////////////////
`timescale 1ns/100ps

module exu_disp #(
  parameter int unsigned OITF_DEPTH = 4,
  parameter int unsigned ITAG_W     = 2
) (
  input  logic                         i_valid,
  output logic                         o_ready,
  input  exu_pipe_pkg::dec_info_t      i_dec,
  input  logic [exu_isa_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_isa_pkg::XLEN-1:0] i_rs2,
  input  exu_pipe_pkg::oitf_match_t    i_match,
  input  logic                         i_oitf_full,
  input  logic [ITAG_W-1:0]            i_alloc_ptr,
  input  logic                         i_lsu_fwd_ena,
  input  logic [exu_isa_pkg::XLEN-1:0] i_lsu_wdat,
  output exu_pipe_pkg::alu_req_t       o_alu,
  input  logic                         i_alu_grant,
  output logic                         o_ld_valid,
  output exu_pipe_pkg::ld_req_t        o_ld,
  input  logic                         i_ld_ready,
  output logic                         o_alloc
);

  logic                         is_alu;
  logic                         is_ld;
  logic                         raw_stall;
  logic                         waw_stall;
  logic [exu_isa_pkg::XLEN-1:0] op_rs1;
  logic [exu_isa_pkg::XLEN-1:0] op_rs2;

  assign is_alu = i_dec.valid & ~i_dec.is_load;
  assign is_ld  = i_dec.valid & i_dec.is_load;

  // Head hit is only safe when its data retires this cycle
  assign raw_stall = i_match.rs1_pend | (i_match.rs1_ret & ~i_lsu_fwd_ena)
                   | i_match.rs2_pend | (i_match.rs2_ret & ~i_lsu_fwd_ena);
  assign waw_stall = is_alu & i_match.rd_pend;

  ////////////////////////////////////////
  // Operand select
  assign op_rs1 = (i_match.rs1_ret & i_lsu_fwd_ena) ? i_lsu_wdat : i_rs1;
  assign op_rs2 = (i_match.rs2_ret & i_lsu_fwd_ena) ? i_lsu_wdat : i_rs2;

  assign o_alu.alu_op = i_dec.alu_op;
  assign o_alu.op1    = op_rs1;
  assign o_alu.op2    = i_dec.rs2en ? op_rs2 : i_dec.imm;
  assign o_alu.rdwen  = is_alu & i_dec.rdwen;
  assign o_alu.rdidx  = i_dec.rdidx;

  ////////////////////////////////////////
  // Load port
  assign o_ld_valid = i_valid & is_ld & ~raw_stall & ~i_oitf_full;
  assign o_ld.addr  = op_rs1 + i_dec.imm;
  assign o_ld.itag  = exu_pipe_pkg::ITAG_FW'(i_alloc_ptr);  // Upper tag bits zero
  assign o_alloc    = o_ld_valid & i_ld_ready;

  // Illegal encodings fall through as accepted no-ops
  always_comb begin
    if (raw_stall) begin
      o_ready = 1'b0;
    end else if (is_alu) begin
      o_ready = ~waw_stall & i_alu_grant;
    end else if (is_ld) begin
      o_ready = i_ld_ready & ~i_oitf_full;
    end else begin
      o_ready = 1'b1;
    end
  end

endmodule

//--- hdl/exu_alu.sv
////////////////////////////////////////
// Single-cycle integer ALU
// Result goes straight to the writeback arbiter
////////////////////////////////////////
`timescale 1ns/100ps

module exu_alu (
  input  exu_pipe_pkg::alu_req_t i_req,
  input  logic                   i_fire,
  output exu_pipe_pkg::wbck_t    o_wbck
);

  logic [exu_isa_pkg::XLEN-1:0] res;

  always_comb begin
    case (i_req.alu_op)
      exu_isa_pkg::ALU_ADD: res = i_req.op1 + i_req.op2;
      exu_isa_pkg::ALU_SUB: res = i_req.op1 - i_req.op2;
      exu_isa_pkg::ALU_AND: res = i_req.op1 & i_req.op2;
      exu_isa_pkg::ALU_OR:  res = i_req.op1 | i_req.op2;
      exu_isa_pkg::ALU_XOR: res = i_req.op1 ^ i_req.op2;
      default:              res = '0;
    endcase
  end

  assign o_wbck.ena   = i_fire & i_req.rdwen;  // Only while issuing
  assign o_wbck.rdidx = i_req.rdidx;
  assign o_wbck.wdat  = res;

endmodule

//--- hdl/exu_wbck.sv
////////////////////////////////////////
// Final writeback arbiter, LSU responses win over the ALU
// Also retires the OITF head and feeds forwarding
////////////////////////////////////////
`timescale 1ns/100ps

module exu_wbck #(
  parameter int unsigned ITAG_W = 2
) (
  input  logic                         i_lsu_valid,
  input  exu_pipe_pkg::lsu_rsp_t       i_lsu,
  output logic                         o_lsu_ready,
  input  exu_pipe_pkg::ret_t           i_ret,
  output logic                         o_ret_ena,
  input  exu_pipe_pkg::wbck_t          i_alu_wbck,
  output logic                         o_alu_grant,
  output logic                         o_fwd_ena,
  output logic [exu_isa_pkg::XLEN-1:0] o_fwd_wdat,
  output exu_pipe_pkg::wbck_t          o_wbck
);

  logic tag_ok;
  logic lsu_wr;

  // A response tag outside the OITF range writes nothing
  assign tag_ok = ((i_lsu.itag >> ITAG_W) == '0);

  assign o_lsu_ready = i_lsu_valid;
  assign o_ret_ena   = i_lsu_valid & o_lsu_ready;
  assign o_alu_grant = ~i_lsu_valid;

  assign lsu_wr = i_lsu_valid & i_ret.ena & i_ret.rdwen & tag_ok;

  // Forward the retiring load data to dispatch
  assign o_fwd_ena  = lsu_wr;
  assign o_fwd_wdat = i_lsu.wdat;

  always_comb begin
    if (i_lsu_valid) begin
      o_wbck.ena   = lsu_wr;
      o_wbck.rdidx = i_ret.rdidx;  // rd comes from the OITF, not the LSU
      o_wbck.wdat  = i_lsu.wdat;
    end else begin
      o_wbck = i_alu_wbck;
    end
  end

endmodule

//--- hdl/exu_top.sv
////////////////////////////////////////
// Reduced RV32 execution stage
// Instruction in, load requests out, register writes exported
////////////////////////////////////////
`timescale 1ns/100ps

module exu_top #(
  parameter int unsigned OITF_DEPTH = 4  // Power of two
) (
  input  logic                            clk,
  input  logic                            i_rst,
  input  logic                            i_valid,
  input  logic [exu_isa_pkg::INSTR_W-1:0] i_instr,
  output logic                            o_ready,
  output logic                            o_ld_valid,
  output exu_pipe_pkg::ld_req_t           o_ld,
  input  logic                            i_ld_ready,
  input  logic                            i_lsu_valid,
  input  exu_pipe_pkg::lsu_rsp_t          i_lsu,
  output logic                            o_lsu_ready,
  output exu_pipe_pkg::wbck_t             o_wbck,
  output logic                            o_oitf_empty
);

  localparam int unsigned ITAG_W = $clog2(OITF_DEPTH);

  exu_pipe_pkg::dec_info_t      dec;
  logic [exu_isa_pkg::XLEN-1:0] rf_rs1;
  logic [exu_isa_pkg::XLEN-1:0] rf_rs2;
  exu_pipe_pkg::oitf_match_t    oitf_match;
  logic                         oitf_full;
  logic [ITAG_W-1:0]            alloc_ptr;
  logic                         alloc;
  exu_pipe_pkg::ret_t           oitf_ret;
  logic                         ret_ena;
  exu_pipe_pkg::alu_req_t       alu_req;
  exu_pipe_pkg::wbck_t          alu_wbck;
  logic                         alu_grant;
  logic                         fwd_ena;
  logic [exu_isa_pkg::XLEN-1:0] fwd_wdat;

  exu_decode u_decode (.i_instr(i_instr), .o_dec(dec));

  exu_regfile u_regfile (
    .clk(clk), .i_rst(i_rst),
    .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx),
    .o_rs1(rf_rs1), .o_rs2(rf_rs2),
    .i_wbck(o_wbck)
  );

  exu_oitf #(.OITF_DEPTH(OITF_DEPTH), .ITAG_W(ITAG_W)) u_oitf (
    .clk(clk), .i_rst(i_rst),
    .i_alloc(alloc), .i_alloc_rdwen(dec.rdwen), .i_alloc_rdidx(dec.rdidx),
    .o_alloc_ptr(alloc_ptr),
    .i_ret_ena(ret_ena), .o_ret(oitf_ret),
    .i_rs1en(dec.rs1en), .i_rs2en(dec.rs2en), .i_rdwen(dec.rdwen),
    .i_rs1idx(dec.rs1idx), .i_rs2idx(dec.rs2idx), .i_rdidx(dec.rdidx),
    .o_match(oitf_match), .o_full(oitf_full), .o_empty(o_oitf_empty)
  );

  exu_disp #(.OITF_DEPTH(OITF_DEPTH), .ITAG_W(ITAG_W)) u_disp (
    .i_valid(i_valid), .o_ready(o_ready), .i_dec(dec),
    .i_rs1(rf_rs1), .i_rs2(rf_rs2),
    .i_match(oitf_match), .i_oitf_full(oitf_full), .i_alloc_ptr(alloc_ptr),
    .i_lsu_fwd_ena(fwd_ena), .i_lsu_wdat(fwd_wdat),
    .o_alu(alu_req), .i_alu_grant(alu_grant),
    .o_ld_valid(o_ld_valid), .o_ld(o_ld), .i_ld_ready(i_ld_ready),
    .o_alloc(alloc)
  );

  // Issue happens on the input handshake
  exu_alu u_alu (.i_req(alu_req), .i_fire(i_valid & o_ready), .o_wbck(alu_wbck));

  exu_wbck #(.ITAG_W(ITAG_W)) u_wbck (
    .i_lsu_valid(i_lsu_valid), .i_lsu(i_lsu), .o_lsu_ready(o_lsu_ready),
    .i_ret(oitf_ret), .o_ret_ena(ret_ena),
    .i_alu_wbck(alu_wbck), .o_alu_grant(alu_grant),
    .o_fwd_ena(fwd_ena), .o_fwd_wdat(fwd_wdat),
    .o_wbck(o_wbck)
  );

endmodule

//--- include/exu_tb_cases.svh
////////////////////////////////////////
// Case table for the execution stage testbench, included in the module
// Columns: name, instruction, rd, expected value, writeback expected
////////////////////////////////////////

string       case_name[$];
logic [31:0] case_instr[$];
logic [4:0]  case_rd[$];
logic [31:0] case_exp[$];
bit          case_wb[$];

// R-type, major opcode OP
function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                       logic [4:0] rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

task automatic add_case(string name, logic [31:0] instr, logic [4:0] rd,
                        logic [31:0] exp_val, bit wb);
  case_name.push_back(name);
  case_instr.push_back(instr);
  case_rd.push_back(rd);
  case_exp.push_back(exp_val);
  case_wb.push_back(wb);
endtask

// 7'h13 is OP_IMM, 7'h03 is LOAD
task automatic load_cases();
  add_case("addi_x1", i_type(7'h13, 3'h0, 5'd1, 5'd0, 12'h5A3), 5'd1, 32'h000005A3, 1);
  add_case("addi_neg", i_type(7'h13, 3'h0, 5'd2, 5'd0, 12'hFF0), 5'd2, 32'hFFFFFFF0, 1);
  add_case("add", r_type(7'h00, 3'h0, 5'd3, 5'd1, 5'd2), 5'd3, 32'h5A3 + 32'hFFFFFFF0, 1);
  add_case("sub", r_type(7'h20, 3'h0, 5'd4, 5'd1, 5'd2), 5'd4, 32'h5A3 - 32'hFFFFFFF0, 1);
  add_case("and", r_type(7'h00, 3'h7, 5'd5, 5'd1, 5'd2), 5'd5, 32'h5A3 & 32'hFFFFFFF0, 1);
  add_case("or", r_type(7'h00, 3'h6, 5'd6, 5'd1, 5'd2), 5'd6, 32'h5A3 | 32'hFFFFFFF0, 1);
  add_case("xor", r_type(7'h00, 3'h4, 5'd7, 5'd1, 5'd2), 5'd7, 32'h5A3 ^ 32'hFFFFFFF0, 1);
  add_case("addi_x0", i_type(7'h13, 3'h0, 5'd0, 5'd1, 12'h007), 5'd0, 32'h0, 0);
  add_case("read_x0", r_type(7'h00, 3'h0, 5'd8, 5'd0, 5'd1), 5'd8, 32'h5A3, 1);
  add_case("lw_x9", i_type(7'h03, 3'h2, 5'd9, 5'd1, 12'h040), 5'd9, 32'h5E3 ^ LSU_KEY, 1);
  add_case("load_use", r_type(7'h00, 3'h0, 5'd10, 5'd9, 5'd1), 5'd10,
           (32'h5E3 ^ LSU_KEY) + 32'h5A3, 1);
  add_case("lw_x11", i_type(7'h03, 3'h2, 5'd11, 5'd1, 12'h100), 5'd11, 32'h6A3 ^ LSU_KEY, 1);
  add_case("lw_x12", i_type(7'h03, 3'h2, 5'd12, 5'd1, 12'h200), 5'd12, 32'h7A3 ^ LSU_KEY, 1);
  add_case("lw_x13", i_type(7'h03, 3'h2, 5'd13, 5'd1, 12'h300), 5'd13, 32'h8A3 ^ LSU_KEY, 1);
  add_case("lw_x14", i_type(7'h03, 3'h2, 5'd14, 5'd1, 12'h400), 5'd14, 32'h9A3 ^ LSU_KEY, 1);
  add_case("lw_x15", i_type(7'h03, 3'h2, 5'd15, 5'd0, 12'h010), 5'd15, 32'h010 ^ LSU_KEY, 1);
  add_case("waw_x15", i_type(7'h13, 3'h0, 5'd15, 5'd0, 12'h077), 5'd15, 32'h77, 1);
  add_case("read_x15", r_type(7'h00, 3'h0, 5'd16, 5'd15, 5'd0), 5'd16, 32'h77, 1);
endtask

//--- test/exu_tb.sv
////////////////////////////////////////
// Testbench for the reduced RV32 execution stage
// Runs the case table through the DUT against a random-latency LSU model
////////////////////////////////////////
`timescale 1ns/100ps

module exu_tb;

  localparam logic [31:0] LSU_KEY    = 32'h5A5A0000;  // Load data is address ^ key
  localparam int          OITF_DEPTH = 4;

  logic                   clk;
  logic                   i_rst;
  logic                   i_valid;
  logic [31:0]            i_instr;
  logic                   o_ready;
  logic                   o_ld_valid;
  exu_pipe_pkg::ld_req_t  o_ld;
  logic                   i_ld_ready;
  logic                   i_lsu_valid;
  exu_pipe_pkg::lsu_rsp_t i_lsu;
  logic                   o_lsu_ready;
  exu_pipe_pkg::wbck_t    o_wbck;
  logic                   o_oitf_empty;

  exu_pipe_pkg::ld_req_t ld_q[$];    // Loads waiting for a response
  int                    pend_q[$];  // Cases waiting for their writeback
  int                    cur_case;
  int                    n_pass;
  int                    n_fail;
  int                    n_done;
  int                    n_loads;
  int                    cycles;
  int                    limit;

  `include "exu_tb_cases.svh"

  exu_top #(.OITF_DEPTH(OITF_DEPTH)) UUT (
    .clk(clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr), .o_ready(o_ready),
    .o_ld_valid(o_ld_valid), .o_ld(o_ld), .i_ld_ready(i_ld_ready),
    .i_lsu_valid(i_lsu_valid), .i_lsu(i_lsu), .o_lsu_ready(o_lsu_ready),
    .o_wbck(o_wbck), .o_oitf_empty(o_oitf_empty)
  );

  task automatic check_result(input int idx, input logic [31:0] act);
    if (act === case_exp[idx]) begin
      $display("PASS %s", case_name[idx]);
      n_pass++;
    end else begin
      $display("FAIL %s expected %h actual %h", case_name[idx], case_exp[idx], act);
      n_fail++;
    end
    n_done++;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // LSU model, in-order responses after 1 to 6 cycles
  initial begin
    int                    wait_cyc;
    exu_pipe_pkg::ld_req_t req;
    i_ld_ready  = 1'b0;
    i_lsu_valid = 1'b0;
    i_lsu       = '0;
    wait_cyc    = 0;
    void'($urandom(27476));
    forever begin
      @(negedge clk);
      i_ld_ready  = ($urandom % 4) != 0;  // Low about a quarter of the time
      i_lsu_valid = 1'b0;
      if (wait_cyc > 0) begin
        wait_cyc--;
        if (wait_cyc == 0) begin
          req         = ld_q.pop_front();
          i_lsu_valid = 1'b1;
          i_lsu.wdat  = req.addr ^ LSU_KEY;
          i_lsu.itag  = req.itag;
        end
      end else if (ld_q.size() > 0) begin
        wait_cyc = 1 + $urandom % 6;
      end
    end
  end

  ////////////////////////////////////////
  // Scoreboard
  always @(posedge clk) begin
    int idx;
    if (!i_rst) begin
      if (o_ld_valid && i_ld_ready) begin
        // Tags count up through the OITF slots
        if (o_ld.itag !== exu_pipe_pkg::ITAG_FW'(n_loads % OITF_DEPTH)) begin
          $display("FAIL %s expected itag %0d actual %0d",
                   case_name[cur_case], n_loads % OITF_DEPTH, o_ld.itag);
          n_fail++;
        end
        n_loads++;
        ld_q.push_back(o_ld);
      end
      if (i_lsu_valid && !o_lsu_ready) begin
        $display("LSU response with tag %0d was not accepted", i_lsu.itag);
        n_fail++;
      end
      if (i_valid && o_ready) begin
        if (case_wb[cur_case]) begin
          pend_q.push_back(cur_case);
        end else if (o_wbck.ena) begin
          $display("FAIL %s expected no writeback actual x%0d = %h",
                   case_name[cur_case], o_wbck.rdidx, o_wbck.wdat);
          n_fail++;
          n_done++;
        end else begin
          $display("PASS %s", case_name[cur_case]);
          n_pass++;
          n_done++;
        end
      end
      if (o_wbck.ena) begin
        idx = -1;
        for (int j = 0; j < pend_q.size() && idx < 0; j++) begin
          if (case_rd[pend_q[j]] == o_wbck.rdidx) idx = j;  // Oldest with this rd
        end
        if (idx < 0) begin
          $display("Unexpected writeback of %h to x%0d", o_wbck.wdat, o_wbck.rdidx);
          n_fail++;
        end else begin
          check_result(pend_q[idx], o_wbck.wdat);
          pend_q.delete(idx);
        end
      end
    end
  end

  initial begin
    do begin
      @(posedge clk);
      cycles++;
    end while (cycles < limit);
    $display("Run timed out after %0d cycles with %0d writebacks missing",
             cycles, case_name.size() - n_done);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  initial begin
    i_rst    = 1'b1;
    i_valid  = 1'b0;
    i_instr  = '0;
    cur_case = 0;
    load_cases();
    limit = case_name.size() * 12 + 100;
    repeat (16) @(negedge clk);
    i_rst = 1'b0;
    @(posedge clk);
    if (o_ready && !o_ld_valid && !o_lsu_ready && !o_wbck.ena && o_oitf_empty) begin
      $display("PASS reset_state");
      n_pass++;
    end else begin
      $display("FAIL reset_state expected 10001 actual %b%b%b%b%b",
               o_ready, o_ld_valid, o_lsu_ready, o_wbck.ena, o_oitf_empty);
      n_fail++;
    end

    foreach (case_instr[i]) begin
      @(negedge clk);
      cur_case = i;
      i_valid  = 1'b1;
      i_instr  = case_instr[i];
      @(posedge clk);
      while (!o_ready) @(posedge clk);  // Held until accepted
    end
    @(negedge clk);
    i_valid = 1'b0;

    while (n_done < case_name.size()) @(negedge clk);
    @(posedge clk);
    if (o_oitf_empty) begin
      $display("PASS oitf_empty");
      n_pass++;
    end else begin
      $display("FAIL oitf_empty expected 1 actual 0");
      n_fail++;
    end

    $display("Counts: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- exu_top.f
+incdir+include
hdl/exu_isa_pkg.sv
hdl/exu_pipe_pkg.sv
hdl/exu_decode.sv
hdl/exu_regfile.sv
hdl/exu_oitf.sv
hdl/exu_disp.sv
hdl/exu_alu.sv
hdl/exu_wbck.sv
hdl/exu_top.sv
test/exu_tb.sv
